//--- Bender.yml
package:
  name: btb

sources:
  - logic/btbPkg.sv
  - logic/btbRamInit.sv
  - logic/btbBankRam.sv
  - logic/btbFetchAddr.sv
  - logic/btbReadAlign.sv
  - logic/btbWritePort.sv
  - logic/btbTop.sv
  - target: test
    files:
      - test/btbTb.sv

//--- flist.f
logic/btbPkg.sv
logic/btbRamInit.sv
logic/btbBankRam.sv
logic/btbFetchAddr.sv
logic/btbReadAlign.sv
logic/btbWritePort.sv
logic/btbTop.sv
test/btbTb.sv

//--- logic/btbBankRam.sv
`timescale 1ns/1ps

module btbBankRam #(
  parameter int  FetchWidth  = 4,
  parameter int  BtbEntries  = 64,
  localparam int RowsPerBank = BtbEntries / FetchWidth,
  localparam int IdxWidth    = $clog2(RowsPerBank),
  localparam int TagWidth    = btbPkg::PcWidth - $clog2(BtbEntries) - btbPkg::InstByteOffset,
  localparam int EntryWidth  = TagWidth + btbPkg::EntryFixedWidth
) (
  input  logic                  clk,
  input  logic [IdxWidth-1:0]   rdAddr_i,
  output logic [EntryWidth-1:0] rdData_o,
  input  logic [IdxWidth-1:0]   wrAddr_i,
  input  logic [EntryWidth-1:0] wrData_i,
  input  logic                  we_i
);

  // Row array, contents cleared by the init sequencer
  logic [EntryWidth-1:0] rows [RowsPerBank];

  // Asynchronous read
  assign rdData_o = rows[rdAddr_i];

  // Single write port, visible to lookups from the next cycle
  always_ff @(posedge clk)
  begin
    if (we_i)
      rows[wrAddr_i] <= wrData_i;
  end

  // A write with an unknown row would corrupt an arbitrary entry
  wrAddrKnown: assert property (@(posedge clk)
    we_i |-> !$isunknown(wrAddr_i));

endmodule

//--- logic/btbFetchAddr.sv
`timescale 1ns/1ps

module btbFetchAddr #(
  parameter int  FetchWidth = 4,
  parameter int  BtbEntries = 64,
  localparam int OffWidth   = $clog2(FetchWidth),
  localparam int IdxWidth   = $clog2(BtbEntries / FetchWidth),
  localparam int TagWidth   = btbPkg::PcWidth - $clog2(BtbEntries) - btbPkg::InstByteOffset
) (
  input  btbPkg::pcT                          PC_i,
  output logic [FetchWidth-1:0][IdxWidth-1:0] bankRdAddr_o,  // Indexed by bank
  output logic [FetchWidth-1:0][TagWidth-1:0] laneTag_o,     // Indexed by lane
  output logic [OffWidth-1:0]                 rotate_o
);

  import btbPkg::*;

  localparam int SlotWidth = PcWidth - InstByteOffset;  // Instruction address width

  logic [SlotWidth-1:0]                 fetchSlot;
  logic [FetchWidth-1:0][SlotWidth-1:0] laneSlot;
  logic [FetchWidth-1:0][IdxWidth-1:0]  laneIdx;

  assign fetchSlot = PC_i[PcWidth-1:InstByteOffset];

  // Split each consecutive slot into {tag, index, offset}
  always_comb
  begin
    for (int l = 0; l < FetchWidth; l++)
    begin
      laneSlot[l]  = fetchSlot + SlotWidth'(l);  // Carry into index when wrapping
      laneTag_o[l] = laneSlot[l][SlotWidth-1 -: TagWidth];
      laneIdx[l]   = laneSlot[l][OffWidth +: IdxWidth];
    end
  end

  // Lane l sits in bank (rotate + l), so bank b serves lane (b - rotate)
  assign rotate_o = fetchSlot[OffWidth-1:0];

  always_comb
  begin
    logic [OffWidth-1:0] laneSel;
    for (int b = 0; b < FetchWidth; b++)
    begin
      laneSel         = OffWidth'(b) - rotate_o;  // Modulo FetchWidth
      bankRdAddr_o[b] = laneIdx[laneSel];
    end
  end

endmodule

//--- logic/btbPkg.sv
package btbPkg;

  // Fixed machine widths
  parameter int PcWidth        = 32;
  parameter int InstByteOffset = 2;  // 4-byte instructions
  parameter int BrTypeWidth    = 2;

  typedef logic [PcWidth-1:0]     pcT;
  typedef logic [BrTypeWidth-1:0] brTypeT;  // Control type code from decode

  // One lane's lookup result, 35 bits
  typedef struct packed {
    pcT     takenPC;   // Predicted target
    brTypeT ctrlType;
    logic   hit;       // Tag match on a valid entry
  } btbPktT;

  // Stored entry is {tag, takenPC, ctrlType, valid}
  // Tag width depends on module parameters so entries travel as plain vectors
  parameter int EntryFixedWidth = PcWidth + BrTypeWidth + 1;

endpackage

//--- logic/btbRamInit.sv
`timescale 1ns/1ps

module btbRamInit #(
  parameter int  FetchWidth  = 4,
  parameter int  BtbEntries  = 64,
  localparam int RowsPerBank = BtbEntries / FetchWidth,
  localparam int IdxWidth    = $clog2(RowsPerBank)
) (
  input  logic                clk,
  input  logic                resetRams_i,
  output logic                initEn_o,       // High while clearing rows
  output logic [IdxWidth-1:0] initAddr_o,     // Row being cleared
  output logic                btbRamReady_o
);

  typedef enum logic [1:0] {InitStart, InitRun, InitDone} initStateT;

  initStateT           state;
  initStateT           nextState;
  logic [IdxWidth-1:0] nextAddr;

  always_ff @(posedge clk or posedge resetRams_i)
  begin
    if (resetRams_i)
    begin
      state      <= InitStart;
      initAddr_o <= '0;
    end
    else
    begin
      state      <= nextState;
      initAddr_o <= nextAddr;
    end
  end

  // Start for one clock, then one row per clock across all banks
  always_comb
  begin
    nextState = state;
    nextAddr  = initAddr_o;
    case (state)
      InitStart:
      begin
        nextState = InitRun;
        nextAddr  = '0;
      end
      InitRun:
      begin
        nextAddr = initAddr_o + 1'b1;
        if (initAddr_o == IdxWidth'(RowsPerBank - 1))
          nextState = InitDone;  // Last row written this cycle
      end
      default:
      begin
        nextState = InitDone;    // Sticky until next RAM reset
        nextAddr  = '0;
      end
    endcase
  end

  assign initEn_o      = (state == InitRun);
  assign btbRamReady_o = (state == InitDone);  // Low through start and run

  runAddrInRange: assert property (@(posedge clk) disable iff (resetRams_i)
    initEn_o |-> (int'(initAddr_o) < RowsPerBank));

endmodule

//--- logic/btbReadAlign.sv
`timescale 1ns/1ps

module btbReadAlign #(
  parameter int  FetchWidth = 4,
  parameter int  BtbEntries = 64,
  localparam int OffWidth   = $clog2(FetchWidth),
  localparam int TagWidth   = btbPkg::PcWidth - $clog2(BtbEntries) - btbPkg::InstByteOffset,
  localparam int EntryWidth = TagWidth + btbPkg::EntryFixedWidth
) (
  input  logic [FetchWidth-1:0][EntryWidth-1:0] bankRdData_i,  // Bank order
  input  logic [FetchWidth-1:0][TagWidth-1:0]   laneTag_i,     // Lane order
  input  logic [OffWidth-1:0]                   rotate_i,
  output btbPkg::btbPktT [FetchWidth-1:0]       btbPacket_o
);

  import btbPkg::*;

  logic [FetchWidth-1:0][EntryWidth-1:0] laneEntry;   // Back in lane order
  logic [FetchWidth-1:0][TagWidth-1:0]   storedTag;
  pcT   [FetchWidth-1:0]                 storedTarget;
  brTypeT [FetchWidth-1:0]               storedType;
  logic [FetchWidth-1:0]                 storedValid;

  // Rotate bank outputs back, lane l came from bank (rotate + l)
  always_comb
  begin
    logic [OffWidth-1:0] bankSel;
    for (int l = 0; l < FetchWidth; l++)
    begin
      bankSel      = rotate_i + OffWidth'(l);  // Wraps modulo FetchWidth
      laneEntry[l] = bankRdData_i[bankSel];
    end
  end

  // Unpack {tag, takenPC, ctrlType, valid} and compare tags
  always_comb
  begin
    for (int l = 0; l < FetchWidth; l++)
    begin
      {storedTag[l], storedTarget[l], storedType[l], storedValid[l]} = laneEntry[l];
      btbPacket_o[l].takenPC  = storedTarget[l];
      btbPacket_o[l].ctrlType = storedType[l];
      btbPacket_o[l].hit      = storedValid[l] && (storedTag[l] == laneTag_i[l]);
    end
  end

endmodule

//--- logic/btbTop.sv
`timescale 1ns/1ps

module btbTop #(
  parameter int FetchWidth = 4,   // Power of two
  parameter int BtbEntries = 64   // Multiple of FetchWidth
) (
  input  logic                                clk,
  input  logic                                resetRams_i,
  input  btbPkg::pcT                          PC_i,         // Fetch PC, lane 0 slot
  input  logic                                updateEn_i,   // Update strobe from branch order buffer
  input  btbPkg::pcT                          updatePC_i,
  input  btbPkg::pcT                          updateNPC_i,  // Taken target
  input  btbPkg::brTypeT                      updateBrType_i,
  output btbPkg::btbPktT [FetchWidth-1:0]     btbPacket_o,
  output logic                                btbRamReady_o
);

  import btbPkg::*;

  localparam int OffWidth   = $clog2(FetchWidth);
  localparam int IdxWidth   = $clog2(BtbEntries / FetchWidth);
  localparam int TagWidth   = PcWidth - $clog2(BtbEntries) - InstByteOffset;
  localparam int EntryWidth = TagWidth + EntryFixedWidth;

  // Init sequencer to write port
  logic                                initEn;
  logic [IdxWidth-1:0]                 initAddr;

  // Lookup path
  logic [FetchWidth-1:0][IdxWidth-1:0]   bankRdAddr;  // Per bank, already rotated
  logic [FetchWidth-1:0][EntryWidth-1:0] bankRdData;  // Per bank, bank order
  logic [FetchWidth-1:0][TagWidth-1:0]   laneTag;     // Per lane
  logic [OffWidth-1:0]                   rotate;      // Lane 0 offset

  // Write path, one shared row and entry
  logic [IdxWidth-1:0]                 bankWrAddr;
  logic [EntryWidth-1:0]               bankWrData;
  logic [FetchWidth-1:0]               bankWe;

  btbRamInit #(.FetchWidth(FetchWidth), .BtbEntries(BtbEntries)) u_ramInit (
    .clk           (clk),
    .resetRams_i   (resetRams_i),
    .initEn_o      (initEn),
    .initAddr_o    (initAddr),
    .btbRamReady_o (btbRamReady_o)
  );

  btbFetchAddr #(.FetchWidth(FetchWidth), .BtbEntries(BtbEntries)) u_fetchAddr (
    .PC_i         (PC_i),
    .bankRdAddr_o (bankRdAddr),
    .laneTag_o    (laneTag),
    .rotate_o     (rotate)
  );

  // One bank per fetch slot offset
  for (genvar g = 0; g < FetchWidth; g++)
  begin : genBank
    btbBankRam #(.FetchWidth(FetchWidth), .BtbEntries(BtbEntries)) u_bank (
      .clk      (clk),
      .rdAddr_i (bankRdAddr[g]),
      .rdData_o (bankRdData[g]),
      .wrAddr_i (bankWrAddr),
      .wrData_i (bankWrData),
      .we_i     (bankWe[g])
    );
  end

  btbReadAlign #(.FetchWidth(FetchWidth), .BtbEntries(BtbEntries)) u_readAlign (
    .bankRdData_i (bankRdData),
    .laneTag_i    (laneTag),
    .rotate_i     (rotate),
    .btbPacket_o  (btbPacket_o)
  );

  btbWritePort #(.FetchWidth(FetchWidth), .BtbEntries(BtbEntries)) u_writePort (
    .initEn_i       (initEn),
    .initAddr_i     (initAddr),
    .updateEn_i     (updateEn_i),
    .updatePC_i     (updatePC_i),
    .updateNPC_i    (updateNPC_i),
    .updateBrType_i (updateBrType_i),
    .bankWrAddr_o   (bankWrAddr),
    .bankWrData_o   (bankWrData),
    .bankWe_o       (bankWe)
  );

endmodule

//--- logic/btbWritePort.sv
`timescale 1ns/1ps

module btbWritePort #(
  parameter int  FetchWidth = 4,
  parameter int  BtbEntries = 64,
  localparam int OffWidth   = $clog2(FetchWidth),
  localparam int IdxWidth   = $clog2(BtbEntries / FetchWidth),
  localparam int TagWidth   = btbPkg::PcWidth - $clog2(BtbEntries) - btbPkg::InstByteOffset,
  localparam int EntryWidth = TagWidth + btbPkg::EntryFixedWidth
) (
  input  logic                  initEn_i,
  input  logic [IdxWidth-1:0]   initAddr_i,
  input  logic                  updateEn_i,
  input  btbPkg::pcT            updatePC_i,
  input  btbPkg::pcT            updateNPC_i,
  input  btbPkg::brTypeT        updateBrType_i,
  output logic [IdxWidth-1:0]   bankWrAddr_o,   // Shared by all banks
  output logic [EntryWidth-1:0] bankWrData_o,
  output logic [FetchWidth-1:0] bankWe_o        // One enable per bank
);

  import btbPkg::*;

  logic [TagWidth-1:0]   updateTag;
  logic [IdxWidth-1:0]   updateRow;
  logic [OffWidth-1:0]   updateOff;   // Selects the bank
  logic [EntryWidth-1:0] updateEntry;

  // Update PC is split the same way as a fetch slot
  assign updateTag = updatePC_i[PcWidth-1 -: TagWidth];
  assign updateRow = updatePC_i[InstByteOffset+OffWidth +: IdxWidth];
  assign updateOff = updatePC_i[InstByteOffset +: OffWidth];

  // New entry always valid
  assign updateEntry = {updateTag, updateNPC_i, updateBrType_i, 1'b1};

  // Init clears one row in every bank and overrides any update
  always_comb
  begin
    if (initEn_i)
    begin
      bankWrAddr_o = initAddr_i;
      bankWrData_o = '0;          // Valid bit cleared
      bankWe_o     = '1;
    end
    else
    begin
      bankWrAddr_o = updateRow;
      bankWrData_o = updateEntry;
      bankWe_o     = updateEn_i ? (FetchWidth'(1) << updateOff) : '0;
    end
  end

endmodule

//--- test/btbCases.txt
# U updatePC target type
# L fetchPC, then per lane 0..3: hit target type (target and type checked on hit only)
# Empty after init
L 00000000 0 0 0 0 0 0 0 0 0 0 0 0
L 00001234 0 0 0 0 0 0 0 0 0 0 0 0
L fffffffc 0 0 0 0 0 0 0 0 0 0 0 0
L 000020a8 0 0 0 0 0 0 0 0 0 0 0 0
# Aligned hit, bank 0 row 0
U 00001000 00002000 1
L 00001000 1 00002000 1 0 0 0 0 0 0 0 0 0
# Same slot reached from lane 1
L 00000ffc 0 0 0 1 00002000 1 0 0 0 0 0 0
# Rotated lookup, lane 3 wraps into next row
U 000010f8 00003010 2
U 00001100 00003020 3
L 000010f4 0 0 0 1 00003010 2 0 0 0 1 00003020 3
L 000010fc 0 0 0 1 00003020 3 0 0 0 0 0 0
# 1100 replaced 1000 in bank 0 row 0, tag now differs
L 00001000 0 0 0 0 0 0 0 0 0 0 0 0
# Tag mismatch at same index and bank
U 00002040 00005000 2
L 00002040 1 00005000 2 0 0 0 0 0 0 0 0 0
L 00003040 0 0 0 0 0 0 0 0 0 0 0 0
L 00012040 0 0 0 0 0 0 0 0 0 0 0 0
# Two hits in one packet
U 00002048 00000abc 0
L 00002040 1 00005000 2 0 0 0 1 00000abc 0 0 0 0
L 0000203c 0 0 0 1 00005000 2 0 0 0 1 00000abc 0
L 00002044 0 0 0 1 00000abc 0 0 0 0 0 0 0
# Overwrite same PC twice
U 00002040 00006000 3
L 00002040 1 00006000 3 0 0 0 1 00000abc 0 0 0 0
U 00002040 00007ffc 1
L 00002040 1 00007ffc 1 0 0 0 1 00000abc 0 0 0 0
L 0000203c 0 0 0 1 00007ffc 1 0 0 0 1 00000abc 0
# Wrap past top of address space into slot 0
U 00000000 0000beef 2
L fffffff8 0 0 0 0 0 0 1 0000beef 2 0 0 0
L 00000000 1 0000beef 2 0 0 0 0 0 0 0 0 0
# Slot 0 replaced 1100
L 00001100 0 0 0 0 0 0 0 0 0 0 0 0
L 000010f4 0 0 0 1 00003010 2 0 0 0 0 0 0

//--- test/btbTb.sv
`timescale 1ns/1ps

module btbTb;

  import btbPkg::*;

  localparam int    Lanes       = 4;   // Default FetchWidth, case file has 4 lane columns
  localparam int    Entries     = 64;
  localparam int    InitCycles  = Entries / Lanes;  // One row per clock
  localparam int    ResetCycles = 4;
  localparam string CaseFile    = "test/btbCases.txt";

  logic                    clk;
  logic                    resetRams_i;
  pcT                      pc;
  logic                    updateEn;
  pcT                      updatePc;
  pcT                      updateNpc;
  brTypeT                  updateBrType;
  btbPktT [Lanes-1:0]      btbPacket;
  logic                    btbRamReady;

  // Parsed cases, one entry per U or L line
  bit                          caseIsUpd [$];
  int                          caseLine  [$];
  logic [PcWidth-1:0]          casePc    [$];
  logic [PcWidth-1:0]          caseNpc   [$];
  logic [BrTypeWidth-1:0]      caseType  [$];
  logic [Lanes-1:0]            caseExpHit [$];
  logic [Lanes*PcWidth-1:0]    caseExpTgt [$];
  logic [Lanes*BrTypeWidth-1:0] caseExpTyp [$];

  int errorCount   = 0;
  int passedTests  = 0;
  int failedTests  = 0;
  int cycleCount   = 0;
  int timeoutLimit = InitCycles + 50;  // Raised once the case count is known
  bit readySeen    = 0;
  bit loadOk;

  btbTop #(.FetchWidth(Lanes), .BtbEntries(Entries)) u_dut (
    .clk            (clk),
    .resetRams_i    (resetRams_i),
    .PC_i           (pc),
    .updateEn_i     (updateEn),
    .updatePC_i     (updatePc),
    .updateNPC_i    (updateNpc),
    .updateBrType_i (updateBrType),
    .btbPacket_o    (btbPacket),
    .btbRamReady_o  (btbRamReady)
  );

  always #4 clk = ~clk;  // 8 ns period

  // Run limit
  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount >= timeoutLimit)
    begin
      $display("Timeout: run did not finish within %0d cycles", timeoutLimit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // Ready must not drop once it has risen
  always @(negedge clk)
  begin
    if (readySeen)
      assert (btbRamReady === 1'b1)
      else
      begin
        $display("CHECK FAILED btbRamReady_o: got %h, expected %h", btbRamReady, 1'b1);
        errorCount++;
      end
  end

  task automatic markTest(input int errsBefore, input string what);
    if (errorCount == errsBefore)
    begin
      passedTests++;
      $display("%s: ok", what);
    end
    else
    begin
      failedTests++;
      $display("%s: FAILED", what);
    end
  endtask

  task automatic loadCases(output bit ok);
    int          fd;
    int          lineNo;
    int          n;
    string       textLine;
    logic [31:0] pcV;
    logic [31:0] npcV;
    logic [31:0] tyV;
    logic [31:0] hv [Lanes];
    logic [31:0] tv [Lanes];
    logic [31:0] yv [Lanes];
    logic [Lanes-1:0]             hitPk;
    logic [Lanes*PcWidth-1:0]     tgtPk;
    logic [Lanes*BrTypeWidth-1:0] typPk;
    ok     = 1;
    lineNo = 0;
    fd     = $fopen(CaseFile, "r");
    if (fd == 0)
    begin
      $display("Cannot open case file %s", CaseFile);
      ok = 0;
    end
    else
    begin
      while (!$feof(fd))
      begin
        textLine = "";
        n = $fgets(textLine, fd);
        lineNo++;
        if (textLine.len() < 2 || textLine.getc(0) == "#")
          ;  // Blank or comment
        else if (textLine.getc(0) == "U")
        begin
          n = $sscanf(textLine, "U %h %h %h", pcV, npcV, tyV);
          if (n != 3)
          begin
            $display("Case file line %0d is malformed", lineNo);
            ok = 0;
          end
          else
          begin
            caseIsUpd.push_back(1'b1);
            caseLine.push_back(lineNo);
            casePc.push_back(pcV);
            caseNpc.push_back(npcV);
            caseType.push_back(tyV[BrTypeWidth-1:0]);
            caseExpHit.push_back('0);
            caseExpTgt.push_back('0);
            caseExpTyp.push_back('0);
          end
        end
        else if (textLine.getc(0) == "L")
        begin
          n = $sscanf(textLine, "L %h %h %h %h %h %h %h %h %h %h %h %h %h", pcV,
                      hv[0], tv[0], yv[0], hv[1], tv[1], yv[1],
                      hv[2], tv[2], yv[2], hv[3], tv[3], yv[3]);
          if (n != 1 + 3 * Lanes)
          begin
            $display("Case file line %0d is malformed", lineNo);
            ok = 0;
          end
          else
          begin
            for (int l = 0; l < Lanes; l++)
            begin
              hitPk[l]                         = hv[l][0];
              tgtPk[l*PcWidth +: PcWidth]      = tv[l];
              typPk[l*BrTypeWidth +: BrTypeWidth] = yv[l][BrTypeWidth-1:0];
            end
            caseIsUpd.push_back(1'b0);
            caseLine.push_back(lineNo);
            casePc.push_back(pcV);
            caseNpc.push_back('0);
            caseType.push_back('0);
            caseExpHit.push_back(hitPk);
            caseExpTgt.push_back(tgtPk);
            caseExpTyp.push_back(typPk);
          end
        end
        else
        begin
          $display("Case file line %0d has an unknown case kind", lineNo);
          ok = 0;
        end
      end
      $fclose(fd);
      if (caseIsUpd.size() == 0)
      begin
        $display("Case file %s holds no cases", CaseFile);
        ok = 0;
      end
    end
  endtask

  task automatic applyReset();
    int errsBefore;
    errsBefore = errorCount;
    repeat (ResetCycles) @(posedge clk);
    assert (btbRamReady === 1'b0)
    else
    begin
      $display("CHECK FAILED btbRamReady_o: got %h, expected %h", btbRamReady, 1'b0);
      errorCount++;
    end
    #1 resetRams_i = 1'b0;
    markTest(errsBefore, "reset: ready held low");
  endtask

  task automatic waitForReady();
    int cycles;
    int errsBefore;
    errsBefore = errorCount;
    cycles     = 0;
    @(negedge clk);
    assert (btbRamReady === 1'b0)  // Still in start state
    else
    begin
      $display("CHECK FAILED btbRamReady_o: got %h, expected %h", btbRamReady, 1'b0);
      errorCount++;
    end
    while (btbRamReady !== 1'b1 && cycles < InitCycles + 2)
    begin
      @(negedge clk);
      cycles++;
    end
    assert (btbRamReady === 1'b1)
    else
    begin
      $display("btbRamReady_o did not rise within %0d cycles after reset", InitCycles + 2);
      errorCount++;
    end
    readySeen = (btbRamReady === 1'b1);
    markTest(errsBefore, $sformatf("init: ready after %0d cycles", cycles));
  endtask

  task automatic doUpdate(input int idx);
    int errsBefore;
    errsBefore = errorCount;
    @(posedge clk);
    #1;
    updatePc     = casePc[idx];
    updateNpc    = caseNpc[idx];
    updateBrType = caseType[idx];
    updateEn     = 1'b1;
    @(posedge clk);  // Write happens here
    #1 updateEn = 1'b0;
    markTest(errsBefore, $sformatf("case %0d (line %0d) update PC %h target %h type %h",
             idx, caseLine[idx], casePc[idx], caseNpc[idx], caseType[idx]));
  endtask

  task automatic checkLookup(input int idx);
    int                     errsBefore;
    int                     l;
    logic                   expHit;
    logic [PcWidth-1:0]     expTgt;
    logic [BrTypeWidth-1:0] expTyp;
    errsBefore = errorCount;
    @(posedge clk);
    #1 pc = casePc[idx];
    @(negedge clk);  // Lookup settled
    for (l = 0; l < Lanes; l++)
    begin
      expHit = caseExpHit[idx][l];
      expTgt = caseExpTgt[idx][l*PcWidth +: PcWidth];
      expTyp = caseExpTyp[idx][l*BrTypeWidth +: BrTypeWidth];
      assert (btbPacket[l].hit === expHit)
      else
      begin
        $display("CHECK FAILED btbPacket_o[%0d].hit: got %h, expected %h",
                 l, btbPacket[l].hit, expHit);
        errorCount++;
      end
      if (expHit)  // Payload is don't care on a miss
      begin
        assert (btbPacket[l].takenPC === expTgt)
        else
        begin
          $display("CHECK FAILED btbPacket_o[%0d].takenPC: got %h, expected %h",
                   l, btbPacket[l].takenPC, expTgt);
          errorCount++;
        end
        assert (btbPacket[l].ctrlType === expTyp)
        else
        begin
          $display("CHECK FAILED btbPacket_o[%0d].ctrlType: got %h, expected %h",
                   l, btbPacket[l].ctrlType, expTyp);
          errorCount++;
        end
      end
    end
    markTest(errsBefore, $sformatf("case %0d (line %0d) lookup PC %h",
             idx, caseLine[idx], casePc[idx]));
  endtask

  initial
  begin
    clk          = 1'b0;
    resetRams_i  = 1'b1;
    pc           = '0;
    updateEn     = 1'b0;
    updatePc     = '0;
    updateNpc    = '0;
    updateBrType = '0;
    loadCases(loadOk);
    if (!loadOk)
    begin
      $display("Simulation finished: FAIL");
      $finish;
    end
    else
    begin
      timeoutLimit = InitCycles + 4 * caseIsUpd.size() + 50;
      applyReset();
      waitForReady();
      for (int i = 0; i < caseIsUpd.size(); i++)
      begin
        if (caseIsUpd[i])
          doUpdate(i);
        else
          checkLookup(i);
      end
      $display("Tests passed: %0d, failed: %0d, check errors: %0d",
               passedTests, failedTests, errorCount);
      if (errorCount == 0 && failedTests == 0)
        $display("Simulation finished: PASS");
      else
        $display("Simulation finished: FAIL");
      $finish;
    end
  end

endmodule
